//--- include/fd_macros.svh
`ifndef FD_MACROS_SVH
`define FD_MACROS_SVH

// Instruction and address width
`define FD_WORD_W 32

// Program words held by the instruction memory
`define FD_MEM_DEPTH 64

// Memory address width and the wider count/index width
`define FD_ADDR_W ($clog2(`FD_MEM_DEPTH))
`define FD_IDX_W (`FD_ADDR_W + 1)

// PC of word 0
`define FD_START_ADDR 32'h8002_0000

// Cycles from issue to decoded output
`define FD_PIPE_DEPTH 2
`define FD_DRAIN_W ($clog2(`FD_PIPE_DEPTH + 1))

`endif

//--- design/fd_pkg.sv
`include "fd_macros.svh"

package fd_pkg;

	typedef logic [`FD_WORD_W-1:0] word_t;

	localparam logic [5:0] OP_RTYPE = 6'b000000;
	localparam logic [5:0] OP_J     = 6'b000010;
	localparam logic [5:0] OP_JAL   = 6'b000011;
	localparam logic [5:0] OP_BEQ   = 6'b000100;
	localparam logic [5:0] OP_BNE   = 6'b000101;
	localparam logic [5:0] OP_BGTZ  = 6'b000111;
	localparam logic [5:0] OP_ADDI  = 6'b001000;
	localparam logic [5:0] OP_ADDIU = 6'b001001;
	localparam logic [5:0] OP_SLTI  = 6'b001010;
	localparam logic [5:0] OP_SLTIU = 6'b001011;
	localparam logic [5:0] OP_ORI   = 6'b001101;
	localparam logic [5:0] OP_XORI  = 6'b001110;
	localparam logic [5:0] OP_LUI   = 6'b001111;
	localparam logic [5:0] OP_MUL   = 6'b011100; // Special2, R format
	localparam logic [5:0] OP_LB    = 6'b100000;
	localparam logic [5:0] OP_LW    = 6'b100011;
	localparam logic [5:0] OP_LBU   = 6'b100100;
	localparam logic [5:0] OP_SB    = 6'b101000;
	localparam logic [5:0] OP_SW    = 6'b101011;

	localparam logic [5:0] FN_SLL   = 6'b000000;
	localparam logic [5:0] FN_SRL   = 6'b000010;
	localparam logic [5:0] FN_MUL   = 6'b000010; // Only under OP_MUL
	localparam logic [5:0] FN_SRA   = 6'b000011;
	localparam logic [5:0] FN_SLLV  = 6'b000100;
	localparam logic [5:0] FN_SRLV  = 6'b000110;
	localparam logic [5:0] FN_SRAV  = 6'b000111;
	localparam logic [5:0] FN_JR    = 6'b001000;
	localparam logic [5:0] FN_JALR  = 6'b001001;
	localparam logic [5:0] FN_MFHI  = 6'b010000;
	localparam logic [5:0] FN_MFLO  = 6'b010010;
	localparam logic [5:0] FN_MULT  = 6'b011000;
	localparam logic [5:0] FN_MULTU = 6'b011001;
	localparam logic [5:0] FN_DIV   = 6'b011010;
	localparam logic [5:0] FN_DIVU  = 6'b011011;
	localparam logic [5:0] FN_ADD   = 6'b100000;
	localparam logic [5:0] FN_ADDU  = 6'b100001;
	localparam logic [5:0] FN_SUB   = 6'b100010;
	localparam logic [5:0] FN_SUBU  = 6'b100011;
	localparam logic [5:0] FN_AND   = 6'b100100;
	localparam logic [5:0] FN_OR    = 6'b100101;
	localparam logic [5:0] FN_XOR   = 6'b100110;
	localparam logic [5:0] FN_NOR   = 6'b100111;
	localparam logic [5:0] FN_SLT   = 6'b101010;
	localparam logic [5:0] FN_SLTU  = 6'b101011;

	typedef enum logic [2:0] {
		CLASS_NOP, CLASS_R, CLASS_I, CLASS_J, CLASS_UNKNOWN
	} insn_class_e;

	typedef enum logic [5:0] {
		MN_NOP, MN_UNKNOWN,
		MN_ADD, MN_ADDU, MN_SUB, MN_SUBU, MN_MUL, MN_MULT, MN_MULTU, MN_DIV, MN_DIVU,
		MN_MFHI, MN_MFLO, MN_SLT, MN_SLTU, MN_SLL, MN_SLLV, MN_SRL, MN_SRLV,
		MN_SRA, MN_SRAV, MN_AND, MN_OR, MN_XOR, MN_NOR, MN_JALR, MN_JR,
		MN_ADDI, MN_ADDIU, MN_SLTI, MN_SLTIU, MN_ORI, MN_XORI, MN_LW, MN_SW,
		MN_LB, MN_LUI, MN_SB, MN_LBU, MN_BEQ, MN_BNE, MN_BGTZ,
		MN_J, MN_JAL
	} mnemonic_e;

	typedef struct packed {
		word_t pc;
		word_t insn;
	} fetch_t;

	typedef struct packed {
		word_t       pc;
		word_t       insn;
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic [4:0]  sa;
		logic [5:0]  func;
		logic [15:0] imm;
		logic [25:0] target;
		insn_class_e insn_class;
		mnemonic_e   mnemonic;
	} decoded_t;

endpackage

//--- design/fd_stage_reg.sv
`timescale 1ns/1ps

module fd_stage_reg #(
	parameter type payload_t = logic
) (
	input  logic     clock,
	input  logic     rst,
	input  logic     in_valid,
	input  payload_t in_data,
	output logic     out_valid,
	output payload_t out_data
);

	always_ff @(posedge clock) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (in_valid) begin
			out_data <= in_data; // Holds between valid cycles
		end
	end

endmodule

//--- design/fd_insn_mem.sv
`timescale 1ns/1ps
`include "fd_macros.svh"

module fd_insn_mem (
	input  logic                 clock,
	input  logic                 we,
	input  logic [`FD_IDX_W-1:0] waddr,
	input  logic [`FD_IDX_W-1:0] raddr,
	input  fd_pkg::word_t        wdata,
	output fd_pkg::word_t        rdata
);

	localparam int ADDR_W = `FD_ADDR_W;

	fd_pkg::word_t mem [`FD_MEM_DEPTH];

	always_ff @(posedge clock) begin
		if (we && !waddr[ADDR_W]) begin
			mem[waddr[ADDR_W-1:0]] <= wdata;
		end
	end

	// Index one past the end reads back as zero
	always_ff @(posedge clock) begin
		if (raddr[ADDR_W]) begin
			rdata <= '0;
		end else begin
			rdata <= mem[raddr[ADDR_W-1:0]];
		end
	end

endmodule

//--- design/fd_word_counter.sv
`timescale 1ns/1ps
`include "fd_macros.svh"

module fd_word_counter (
	input  logic                 clock,
	input  logic                 rst,
	input  logic                 mem_we,
	input  logic                 issue,
	input  logic                 drain_start,
	input  logic                 clear,
	output logic [`FD_IDX_W-1:0] load_count,
	output logic [`FD_IDX_W-1:0] fetch_index,
	output fd_pkg::word_t        pc,
	output logic                 empty,
	output logic                 full,
	output logic                 last,
	output logic                 drain_done
);

	localparam int IDX_W = `FD_IDX_W;
	localparam int DRAIN_W = `FD_DRAIN_W;

	logic [DRAIN_W-1:0] drain_cnt;

	always_ff @(posedge clock) begin
		if (rst || clear) begin
			load_count <= '0;
			fetch_index <= '0;
			pc <= `FD_START_ADDR;
		end else begin
			if (mem_we) begin
				load_count <= load_count + IDX_W'(1);
			end
			if (issue) begin
				fetch_index <= fetch_index + IDX_W'(1);
				pc <= pc + fd_pkg::word_t'(4); // One word ahead
			end
		end
	end

	// Counts down the words still in the pipe after the last issue
	always_ff @(posedge clock) begin
		if (rst) begin
			drain_cnt <= '0;
		end else if (drain_start) begin
			drain_cnt <= DRAIN_W'(`FD_PIPE_DEPTH);
		end else if (drain_cnt != '0) begin
			drain_cnt <= drain_cnt - DRAIN_W'(1);
		end
	end

	assign empty = (load_count == '0);
	assign full = (load_count == IDX_W'(`FD_MEM_DEPTH));
	assign last = ((fetch_index + IDX_W'(1)) == load_count); // Word being issued is the final one
	assign drain_done = (drain_cnt == DRAIN_W'(1));

endmodule

//--- design/fd_sequencer.sv
`timescale 1ns/1ps

module fd_sequencer (
	input  logic clock,
	input  logic rst,
	input  logic load_valid,
	input  logic run,
	input  logic stall,
	input  logic empty,
	input  logic full,
	input  logic last,
	input  logic drain_done,
	output logic mem_we,
	output logic issue,
	output logic drain_start,
	output logic clear,
	output logic busy,
	output logic done
);

	typedef enum logic [1:0] {
		IDLE,
		RUN,
		DRAIN
	} state_e;

	state_e state;
	state_e state_next;

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		mem_we = 1'b0;
		issue = 1'b0;
		drain_start = 1'b0;
		clear = 1'b0;
		done = 1'b0;
		case (state)
			IDLE: begin
				mem_we = load_valid && !full; // Extra words past full are dropped
				if (run && !empty) begin
					state_next = RUN;
				end
			end
			RUN: begin
				issue = !stall;
				drain_start = issue && last;
				if (issue && last) begin
					state_next = DRAIN;
				end
			end
			DRAIN: begin
				done = drain_done; // Lines up with the last dec_valid
				clear = drain_done;
				if (drain_done) begin
					state_next = IDLE;
				end
			end
			default: begin
				state_next = IDLE;
			end
		endcase
	end

	assign busy = (state != IDLE);

endmodule

//--- design/fd_decoder.sv
`timescale 1ns/1ps

module fd_decoder (
	input  fd_pkg::fetch_t   fetched,
	output fd_pkg::decoded_t decoded
);

	logic [5:0] opcode;
	logic [5:0] func;
	fd_pkg::insn_class_e cls;
	fd_pkg::mnemonic_e mnem;

	assign opcode = fetched.insn[31:26];
	assign func = fetched.insn[5:0];

	always_comb begin
		cls = fd_pkg::CLASS_UNKNOWN;
		mnem = fd_pkg::MN_UNKNOWN;
		if (fetched.insn == '0) begin
			cls = fd_pkg::CLASS_NOP;
			mnem = fd_pkg::MN_NOP;
		end else if (opcode == fd_pkg::OP_RTYPE) begin
			case (func)
				fd_pkg::FN_ADD:   mnem = fd_pkg::MN_ADD;
				fd_pkg::FN_ADDU:  mnem = fd_pkg::MN_ADDU;
				fd_pkg::FN_SUB:   mnem = fd_pkg::MN_SUB;
				fd_pkg::FN_SUBU:  mnem = fd_pkg::MN_SUBU;
				fd_pkg::FN_MULT:  mnem = fd_pkg::MN_MULT;
				fd_pkg::FN_MULTU: mnem = fd_pkg::MN_MULTU;
				fd_pkg::FN_DIV:   mnem = fd_pkg::MN_DIV;
				fd_pkg::FN_DIVU:  mnem = fd_pkg::MN_DIVU;
				fd_pkg::FN_MFHI:  mnem = fd_pkg::MN_MFHI;
				fd_pkg::FN_MFLO:  mnem = fd_pkg::MN_MFLO;
				fd_pkg::FN_SLT:   mnem = fd_pkg::MN_SLT;
				fd_pkg::FN_SLTU:  mnem = fd_pkg::MN_SLTU;
				fd_pkg::FN_SLL:   mnem = fd_pkg::MN_SLL;
				fd_pkg::FN_SLLV:  mnem = fd_pkg::MN_SLLV;
				fd_pkg::FN_SRL:   mnem = fd_pkg::MN_SRL;
				fd_pkg::FN_SRLV:  mnem = fd_pkg::MN_SRLV;
				fd_pkg::FN_SRA:   mnem = fd_pkg::MN_SRA;
				fd_pkg::FN_SRAV:  mnem = fd_pkg::MN_SRAV;
				fd_pkg::FN_AND:   mnem = fd_pkg::MN_AND;
				fd_pkg::FN_OR:    mnem = fd_pkg::MN_OR;
				fd_pkg::FN_XOR:   mnem = fd_pkg::MN_XOR;
				fd_pkg::FN_NOR:   mnem = fd_pkg::MN_NOR;
				fd_pkg::FN_JALR:  mnem = fd_pkg::MN_JALR;
				fd_pkg::FN_JR:    mnem = fd_pkg::MN_JR;
				default:          mnem = fd_pkg::MN_UNKNOWN;
			endcase
			if (mnem != fd_pkg::MN_UNKNOWN) begin
				cls = fd_pkg::CLASS_R;
			end
		end else if (opcode == fd_pkg::OP_MUL) begin
			if (func == fd_pkg::FN_MUL) begin // Other functions here are not listed
				cls = fd_pkg::CLASS_R;
				mnem = fd_pkg::MN_MUL;
			end
		end else begin
			case (opcode)
				fd_pkg::OP_J:     mnem = fd_pkg::MN_J;
				fd_pkg::OP_JAL:   mnem = fd_pkg::MN_JAL;
				fd_pkg::OP_ADDI:  mnem = fd_pkg::MN_ADDI;
				fd_pkg::OP_ADDIU: mnem = fd_pkg::MN_ADDIU;
				fd_pkg::OP_SLTI:  mnem = fd_pkg::MN_SLTI;
				fd_pkg::OP_SLTIU: mnem = fd_pkg::MN_SLTIU;
				fd_pkg::OP_ORI:   mnem = fd_pkg::MN_ORI;
				fd_pkg::OP_XORI:  mnem = fd_pkg::MN_XORI;
				fd_pkg::OP_LW:    mnem = fd_pkg::MN_LW;
				fd_pkg::OP_SW:    mnem = fd_pkg::MN_SW;
				fd_pkg::OP_LB:    mnem = fd_pkg::MN_LB;
				fd_pkg::OP_LUI:   mnem = fd_pkg::MN_LUI;
				fd_pkg::OP_SB:    mnem = fd_pkg::MN_SB;
				fd_pkg::OP_LBU:   mnem = fd_pkg::MN_LBU;
				fd_pkg::OP_BEQ:   mnem = fd_pkg::MN_BEQ;
				fd_pkg::OP_BNE:   mnem = fd_pkg::MN_BNE;
				fd_pkg::OP_BGTZ:  mnem = fd_pkg::MN_BGTZ;
				default:          mnem = fd_pkg::MN_UNKNOWN;
			endcase
			if (mnem == fd_pkg::MN_J || mnem == fd_pkg::MN_JAL) begin
				cls = fd_pkg::CLASS_J;
			end else if (mnem != fd_pkg::MN_UNKNOWN) begin
				cls = fd_pkg::CLASS_I;
			end
		end
	end

	always_comb begin
		decoded.pc = fetched.pc;
		decoded.insn = fetched.insn;
		decoded.opcode = opcode;
		decoded.rs = fetched.insn[25:21];
		decoded.rt = fetched.insn[20:16];
		decoded.rd = fetched.insn[15:11];
		decoded.sa = fetched.insn[10:6];
		decoded.func = func;
		decoded.imm = fetched.insn[15:0];
		decoded.target = fetched.insn[25:0]; // Jump word index
		decoded.insn_class = cls;
		decoded.mnemonic = mnem;
	end

endmodule

//--- design/fd_core.sv
`timescale 1ns/1ps
`include "fd_macros.svh"

module fd_core (
	input  logic             clock,
	input  logic             rst,
	input  logic             load_valid,
	input  logic             run,
	input  logic             stall,
	input  fd_pkg::word_t    load_data,
	output logic             busy,
	output logic             done,
	output logic             dec_valid,
	output fd_pkg::decoded_t dec
);

	logic mem_we;
	logic issue;
	logic drain_start;
	logic clear;
	logic empty;
	logic full;
	logic last;
	logic drain_done;
	logic fetch_valid;
	logic [`FD_IDX_W-1:0] load_count;
	logic [`FD_IDX_W-1:0] fetch_index;
	fd_pkg::word_t pc;
	fd_pkg::word_t mem_rdata;
	fd_pkg::fetch_t fetch_in;
	fd_pkg::fetch_t fetch_q;
	fd_pkg::fetch_t fetched;
	fd_pkg::decoded_t decoded;

	// Word joins from the read port one cycle after issue
	assign fetch_in = '{pc: pc, insn: '0};
	assign fetched = '{pc: fetch_q.pc, insn: mem_rdata};

	fd_sequencer fd_sequencer_inst (
		.clock       (clock),
		.rst         (rst),
		.load_valid  (load_valid),
		.run         (run),
		.stall       (stall),
		.empty       (empty),
		.full        (full),
		.last        (last),
		.drain_done  (drain_done),
		.mem_we      (mem_we),
		.issue       (issue),
		.drain_start (drain_start),
		.clear       (clear),
		.busy        (busy),
		.done        (done)
	);

	fd_word_counter fd_word_counter_inst (
		.clock       (clock),
		.rst         (rst),
		.mem_we      (mem_we),
		.issue       (issue),
		.drain_start (drain_start),
		.clear       (clear),
		.load_count  (load_count),
		.fetch_index (fetch_index),
		.pc          (pc),
		.empty       (empty),
		.full        (full),
		.last        (last),
		.drain_done  (drain_done)
	);

	fd_insn_mem fd_insn_mem_inst (
		.clock (clock),
		.we    (mem_we),
		.waddr (load_count),
		.raddr (fetch_index),
		.wdata (load_data),
		.rdata (mem_rdata)
	);

	fd_stage_reg #(
		.payload_t (fd_pkg::fetch_t)
	) fetch_stage_inst (
		.clock     (clock),
		.rst       (rst),
		.in_valid  (issue),
		.in_data   (fetch_in),
		.out_valid (fetch_valid),
		.out_data  (fetch_q)
	);

	fd_decoder fd_decoder_inst (
		.fetched (fetched),
		.decoded (decoded)
	);

	fd_stage_reg #(
		.payload_t (fd_pkg::decoded_t)
	) decode_stage_inst (
		.clock     (clock),
		.rst       (rst),
		.in_valid  (fetch_valid),
		.in_data   (decoded),
		.out_valid (dec_valid),
		.out_data  (dec)
	);

endmodule

//--- tb/fd_core_tb.sv
`timescale 1ns/1ps
`include "fd_macros.svh"

module fd_core_tb;

	localparam int TIMEOUT_CYCLES = 1000;

	logic clock;
	logic rst;
	logic load_valid;
	logic run;
	logic stall;
	fd_pkg::word_t load_data;
	logic busy;
	logic done;
	logic dec_valid;
	fd_pkg::decoded_t dec;

	integer seed;
	logic [5:0] r_funcs[$];
	logic [5:0] i_opcodes[$];
	fd_pkg::word_t program_words[$];
	fd_pkg::word_t expected_words[$];

	fd_core fd_core_inst (
		.clock      (clock),
		.rst        (rst),
		.load_valid (load_valid),
		.run        (run),
		.stall      (stall),
		.load_data  (load_data),
		.busy       (busy),
		.done       (done),
		.dec_valid  (dec_valid),
		.dec        (dec)
	);

	always #5 clock = ~clock;

	task automatic fail_run(string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$fatal(1, "stopped at first failure");
	endtask

	task automatic check_decoded(string name, fd_pkg::decoded_t got, fd_pkg::decoded_t exp);
		if (got !== exp) begin
			fail_run($sformatf("** Error at %0t: %s = %h (%s), expected %h (%s)",
				$time, name, got, got.mnemonic.name(), exp, exp.mnemonic.name()));
		end
	endtask

	task automatic check_flag(string name, logic got, logic exp);
		if (got !== exp) begin
			fail_run($sformatf("** Error at %0t: %s = %b, expected %b", $time, name, got, exp));
		end
	endtask

	function automatic fd_pkg::mnemonic_e func_mnemonic(logic [5:0] func);
		case (func)
			6'h00: return fd_pkg::MN_SLL;
			6'h02: return fd_pkg::MN_SRL;
			6'h03: return fd_pkg::MN_SRA;
			6'h04: return fd_pkg::MN_SLLV;
			6'h06: return fd_pkg::MN_SRLV;
			6'h07: return fd_pkg::MN_SRAV;
			6'h08: return fd_pkg::MN_JR;
			6'h09: return fd_pkg::MN_JALR;
			6'h10: return fd_pkg::MN_MFHI;
			6'h12: return fd_pkg::MN_MFLO;
			6'h18: return fd_pkg::MN_MULT;
			6'h19: return fd_pkg::MN_MULTU;
			6'h1a: return fd_pkg::MN_DIV;
			6'h1b: return fd_pkg::MN_DIVU;
			6'h20: return fd_pkg::MN_ADD;
			6'h21: return fd_pkg::MN_ADDU;
			6'h22: return fd_pkg::MN_SUB;
			6'h23: return fd_pkg::MN_SUBU;
			6'h24: return fd_pkg::MN_AND;
			6'h25: return fd_pkg::MN_OR;
			6'h26: return fd_pkg::MN_XOR;
			6'h27: return fd_pkg::MN_NOR;
			6'h2a: return fd_pkg::MN_SLT;
			6'h2b: return fd_pkg::MN_SLTU;
			default: return fd_pkg::MN_UNKNOWN;
		endcase
	endfunction

	function automatic fd_pkg::mnemonic_e opcode_mnemonic(logic [5:0] opcode);
		case (opcode)
			6'h02: return fd_pkg::MN_J;
			6'h03: return fd_pkg::MN_JAL;
			6'h04: return fd_pkg::MN_BEQ;
			6'h05: return fd_pkg::MN_BNE;
			6'h07: return fd_pkg::MN_BGTZ;
			6'h08: return fd_pkg::MN_ADDI;
			6'h09: return fd_pkg::MN_ADDIU;
			6'h0a: return fd_pkg::MN_SLTI;
			6'h0b: return fd_pkg::MN_SLTIU;
			6'h0d: return fd_pkg::MN_ORI;
			6'h0e: return fd_pkg::MN_XORI;
			6'h0f: return fd_pkg::MN_LUI;
			6'h20: return fd_pkg::MN_LB;
			6'h23: return fd_pkg::MN_LW;
			6'h24: return fd_pkg::MN_LBU;
			6'h28: return fd_pkg::MN_SB;
			6'h2b: return fd_pkg::MN_SW;
			default: return fd_pkg::MN_UNKNOWN;
		endcase
	endfunction

	function automatic fd_pkg::decoded_t expected_decode(fd_pkg::word_t pc, fd_pkg::word_t insn);
		fd_pkg::decoded_t d;
		d.pc = pc;
		d.insn = insn;
		d.opcode = insn[31:26];
		d.rs = insn[25:21];
		d.rt = insn[20:16];
		d.rd = insn[15:11];
		d.sa = insn[10:6];
		d.func = insn[5:0];
		d.imm = insn[15:0];
		d.target = insn[25:0];
		if (insn == '0) begin
			d.mnemonic = fd_pkg::MN_NOP;
		end else if (d.opcode == 6'h00) begin
			d.mnemonic = func_mnemonic(d.func);
		end else if (d.opcode == 6'h1c && d.func == 6'h02) begin
			d.mnemonic = fd_pkg::MN_MUL; // Special2 multiply
		end else begin
			d.mnemonic = opcode_mnemonic(d.opcode);
		end
		if (d.mnemonic == fd_pkg::MN_NOP) begin
			d.insn_class = fd_pkg::CLASS_NOP;
		end else if (d.mnemonic == fd_pkg::MN_UNKNOWN) begin
			d.insn_class = fd_pkg::CLASS_UNKNOWN;
		end else if (d.opcode == 6'h00 || d.opcode == 6'h1c) begin
			d.insn_class = fd_pkg::CLASS_R;
		end else if (d.opcode == 6'h02 || d.opcode == 6'h03) begin
			d.insn_class = fd_pkg::CLASS_J;
		end else begin
			d.insn_class = fd_pkg::CLASS_I;
		end
		return d;
	endfunction

	function automatic fd_pkg::word_t random_word();
		fd_pkg::word_t r;
		int kind;
		int k;
		kind = $unsigned($random(seed)) % 8;
		k = $unsigned($random(seed)) % 1024;
		r = $random(seed);
		case (kind)
			0: return '0;
			1: return {6'h1c, r[25:6], 6'h02};
			2, 3: return {6'h00, r[25:6], r_funcs[k % r_funcs.size()]};
			4, 5: return {i_opcodes[k % i_opcodes.size()], r[25:0]};
			6: return {6'h1c, r[25:6], 6'h00}; // Multiply opcode with an unlisted function
			default: return r; // Raw word that is often unlisted
		endcase
	endfunction

	task automatic build_program(int n, bit directed);
		program_words.delete();
		if (directed) begin
			program_words.push_back(32'h0000_0000);
			program_words.push_back({6'h1c, 5'd4, 5'd5, 5'd6, 5'd0, 6'h02});
			program_words.push_back({6'h02, 26'h012_3456});
			program_words.push_back({6'h03, 26'h3ff_fffc});
			program_words.push_back({6'h00, 5'd1, 5'd2, 5'd3, 5'd0, 6'h01});
			program_words.push_back({6'h3f, 26'h000_0001});
		end
		while (program_words.size() < n) begin
			program_words.push_back(random_word());
		end
	endtask

	task automatic load_program();
		expected_words.delete();
		for (int i = 0; i < program_words.size(); i++) begin
			@(posedge clock);
			#1;
			load_valid = 1'b1;
			load_data = program_words[i];
			if (i < `FD_MEM_DEPTH) begin
				expected_words.push_back(program_words[i]); // Words past full are dropped
			end
		end
		@(posedge clock);
		#1;
		load_valid = 1'b0;
		load_data = '0;
	endtask

	task automatic pulse_run();
		@(posedge clock);
		#1;
		run = 1'b1;
		@(posedge clock);
		#1;
		run = 1'b0;
	endtask

	task automatic run_program(bit use_stall);
		int received;
		int issued;
		int cycles;
		bit finished;
		bit issue_now;
		bit issue_d1;
		bit issue_d2;
		fd_pkg::word_t pc;
		received = 0;
		issued = 0;
		cycles = 0;
		finished = 1'b0;
		issue_d1 = 1'b0;
		issue_d2 = 1'b0;
		pulse_run();
		while (!finished) begin
			stall = use_stall && (($unsigned($random(seed)) % 3) == 0);
			issue_now = !stall && (issued < expected_words.size());
			@(negedge clock);
			check_flag("busy", busy, 1'b1);
			check_flag("dec_valid", dec_valid, issue_d2); // Issue shows two cycles later
			if (dec_valid) begin
				pc = `FD_START_ADDR + fd_pkg::word_t'(4 * received);
				check_decoded("dec", dec, expected_decode(pc, expected_words[received]));
				received++;
			end
			check_flag("done", done, dec_valid && (received == expected_words.size()));
			finished = done;
			issue_d2 = issue_d1;
			issue_d1 = issue_now;
			if (issue_now) begin
				issued++;
			end
			cycles++;
			if (cycles > TIMEOUT_CYCLES) begin
				fail_run("Timed out waiting for done at the end of the program");
			end
			@(posedge clock);
			#1;
		end
		stall = 1'b0;
		repeat (3) begin
			@(negedge clock);
			check_flag("busy", busy, 1'b0);
			check_flag("dec_valid", dec_valid, 1'b0);
			check_flag("done", done, 1'b0);
		end
	endtask

	initial begin
		seed = 19;
		clock = 1'b0;
		rst = 1'b1;
		load_valid = 1'b0;
		run = 1'b0;
		stall = 1'b0;
		load_data = '0;
		r_funcs = '{6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07, 6'h08, 6'h09,
			6'h10, 6'h12, 6'h18, 6'h19, 6'h1a, 6'h1b, 6'h20, 6'h21,
			6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b};
		i_opcodes = '{6'h02, 6'h03, 6'h04, 6'h05, 6'h07, 6'h08, 6'h09, 6'h0a,
			6'h0b, 6'h0d, 6'h0e, 6'h0f, 6'h20, 6'h23, 6'h24, 6'h28, 6'h2b};
		repeat (2) @(posedge clock);
		#1;
		rst = 1'b0;

		@(negedge clock);
		check_flag("busy", busy, 1'b0);
		check_flag("done", done, 1'b0);
		check_flag("dec_valid", dec_valid, 1'b0);
		pulse_run(); // Nothing loaded yet
		repeat (3) begin
			@(negedge clock);
			check_flag("busy", busy, 1'b0);
			check_flag("dec_valid", dec_valid, 1'b0);
		end

		build_program(20, 1'b1);
		load_program();
		run_program(1'b0);
		load_program(); // Same words again with stalls
		run_program(1'b1);

		build_program(`FD_MEM_DEPTH + 6, 1'b0);
		load_program();
		run_program(1'b0);

		$display("RESULT: PASS");
		$finish;
	end

endmodule

//--- files.f
+incdir+include
design/fd_pkg.sv
design/fd_stage_reg.sv
design/fd_insn_mem.sv
design/fd_word_counter.sv
design/fd_sequencer.sv
design/fd_decoder.sv
design/fd_core.sv
tb/fd_core_tb.sv

//--- Makefile
TOP = fd_core_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f files.f --top-module $(TOP) --Mdir obj_dir -o $(TOP)_sim
	@out=$$(./obj_dir/$(TOP)_sim 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir
